//--- include/mips_cpu_consts.svh
`ifndef MIPS_CPU_CONSTS_SVH
`define MIPS_CPU_CONSTS_SVH

// Datapath sizes
`define WORD_WIDTH       32
`define REG_ADDR_WIDTH   5
`define REG_COUNT        32
`define REG_V0           2

// Program counter values with special meaning
`define RESET_VECTOR     32'hBFC00000
`define HALT_ADDRESS     32'h00000000

// Major opcodes
`define OPCODE_SPECIAL   6'h00
`define OPCODE_J         6'h02
`define OPCODE_BEQ       6'h04
`define OPCODE_BNE       6'h05
`define OPCODE_ADDIU     6'h09
`define OPCODE_SLTI      6'h0a
`define OPCODE_SLTIU     6'h0b
`define OPCODE_ANDI      6'h0c
`define OPCODE_ORI       6'h0d
`define OPCODE_XORI      6'h0e
`define OPCODE_LUI       6'h0f
`define OPCODE_LW        6'h23
`define OPCODE_SW        6'h2b

// R-type function codes
`define FUNCTION_SLL     6'h00
`define FUNCTION_SRL     6'h02
`define FUNCTION_SRA     6'h03
`define FUNCTION_JR      6'h08
`define FUNCTION_ADDU    6'h21
`define FUNCTION_SUBU    6'h23
`define FUNCTION_AND     6'h24
`define FUNCTION_OR      6'h25
`define FUNCTION_XOR     6'h26
`define FUNCTION_SLT     6'h2a
`define FUNCTION_SLTU    6'h2b

// ALU operations
`define ALU_ADD          4'd0
`define ALU_SUB          4'd1
`define ALU_AND          4'd2
`define ALU_OR           4'd3
`define ALU_XOR          4'd4
`define ALU_SLT          4'd5
`define ALU_SLTU         4'd6
`define ALU_SLL          4'd7
`define ALU_SRL          4'd8
`define ALU_SRA          4'd9
`define ALU_PASS_B       4'd10

// Control-flow kinds
`define FLOW_NONE        3'd0
`define FLOW_BEQ         3'd1
`define FLOW_BNE         3'd2
`define FLOW_J           3'd3
`define FLOW_JR          3'd4

`endif

//--- source/mips_cpu_pkg.sv
`include "mips_cpu_consts.svh"

package mips_cpu_pkg;

    // Data, address and instruction words share one width
    typedef logic [`WORD_WIDTH-1:0] word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [4:0] shamt_t;

    // Selectors, values come from the ALU_ and FLOW_ macros
    typedef logic [3:0] alu_op_t;
    typedef logic [2:0] flow_t;

    // Multicycle sequencing
    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM_ACCESS,
        HALTED
    } cpu_state_t;

endpackage

//--- source/mips_alu.sv
`timescale 1ns/1ps

`include "mips_cpu_consts.svh"

module mips_alu (
    input  mips_cpu_pkg::alu_op_t alu_op,
    input  mips_cpu_pkg::word_t   rs_value,
    input  mips_cpu_pkg::word_t   rt_value,
    input  mips_cpu_pkg::word_t   imm_value,
    input  logic                  use_imm,
    input  mips_cpu_pkg::shamt_t  shamt,
    output mips_cpu_pkg::word_t   result,
    output logic                  operands_equal
);
    import mips_cpu_pkg::*;

    word_t operand_b;
    logic  less_signed;
    logic  less_unsigned;

    assign operand_b = use_imm ? imm_value : rt_value;

    assign less_signed = $signed(rs_value) < $signed(operand_b);
    assign less_unsigned = rs_value < operand_b;

    // Branch compare always uses the two registers
    assign operands_equal = (rs_value == rt_value);

    always_comb begin
        case (alu_op)
            `ALU_ADD:    result = rs_value + operand_b;
            `ALU_SUB:    result = rs_value - operand_b;
            `ALU_AND:    result = rs_value & operand_b;
            `ALU_OR:     result = rs_value | operand_b;
            `ALU_XOR:    result = rs_value ^ operand_b;
            `ALU_SLT:    result = {31'b0, less_signed};
            `ALU_SLTU:   result = {31'b0, less_unsigned};
            // Shifts act on rt by the instruction's shift amount
            `ALU_SLL:    result = rt_value << shamt;
            `ALU_SRL:    result = rt_value >> shamt;
            `ALU_SRA:    result = $unsigned($signed(rt_value) >>> shamt);
            `ALU_PASS_B: result = operand_b;
            default:     result = '0;
        endcase
    end

endmodule

//--- source/mips_decoder.sv
`timescale 1ns/1ps

`include "mips_cpu_consts.svh"

module mips_decoder (
    input  mips_cpu_pkg::word_t     instr,
    output mips_cpu_pkg::reg_addr_t rs,
    output mips_cpu_pkg::reg_addr_t rt,
    output mips_cpu_pkg::reg_addr_t wb_addr,
    output mips_cpu_pkg::alu_op_t   alu_op,
    output logic                    use_imm,
    output mips_cpu_pkg::word_t     imm_value,
    output mips_cpu_pkg::shamt_t    shamt,
    output mips_cpu_pkg::flow_t     flow,
    output logic                    mem_read,
    output logic                    mem_write,
    output logic                    wb_enable
);
    import mips_cpu_pkg::*;

    opcode_t   opcode;
    funct_t    funct;
    reg_addr_t rd;
    logic      writes_reg;
    word_t     imm_sign;
    word_t     imm_zero;

    assign opcode = instr[31:26];
    assign rs = instr[25:21];
    assign rt = instr[20:16];
    assign rd = instr[15:11];
    assign shamt = instr[10:6];
    assign funct = instr[5:0];

    assign imm_sign = {{16{instr[15]}}, instr[15:0]};
    assign imm_zero = {16'h0000, instr[15:0]};

    assign wb_addr = (opcode == `OPCODE_SPECIAL) ? rd : rt;

    // Register 0 is never a write target
    assign wb_enable = writes_reg && (wb_addr != '0);

    always_comb begin
        alu_op = `ALU_ADD;
        use_imm = 1'b0;
        imm_value = imm_sign;
        flow = `FLOW_NONE;
        mem_read = 1'b0;
        mem_write = 1'b0;
        writes_reg = 1'b0;

        case (opcode)
            `OPCODE_SPECIAL: begin
                writes_reg = 1'b1;
                case (funct)
                    `FUNCTION_ADDU: alu_op = `ALU_ADD;
                    `FUNCTION_SUBU: alu_op = `ALU_SUB;
                    `FUNCTION_AND:  alu_op = `ALU_AND;
                    `FUNCTION_OR:   alu_op = `ALU_OR;
                    `FUNCTION_XOR:  alu_op = `ALU_XOR;
                    `FUNCTION_SLT:  alu_op = `ALU_SLT;
                    `FUNCTION_SLTU: alu_op = `ALU_SLTU;
                    `FUNCTION_SLL:  alu_op = `ALU_SLL;
                    `FUNCTION_SRL:  alu_op = `ALU_SRL;
                    `FUNCTION_SRA:  alu_op = `ALU_SRA;
                    `FUNCTION_JR: begin
                        writes_reg = 1'b0;
                        flow = `FLOW_JR;
                    end
                    // Unknown function codes fall through as no-ops
                    default: writes_reg = 1'b0;
                endcase
            end
            `OPCODE_ADDIU: begin
                use_imm = 1'b1;
                writes_reg = 1'b1;
            end
            `OPCODE_SLTI: begin
                alu_op = `ALU_SLT;
                use_imm = 1'b1;
                writes_reg = 1'b1;
            end
            `OPCODE_SLTIU: begin
                alu_op = `ALU_SLTU;
                use_imm = 1'b1;
                writes_reg = 1'b1;
            end
            `OPCODE_ANDI: begin
                alu_op = `ALU_AND;
                use_imm = 1'b1;
                imm_value = imm_zero;
                writes_reg = 1'b1;
            end
            `OPCODE_ORI: begin
                alu_op = `ALU_OR;
                use_imm = 1'b1;
                imm_value = imm_zero;
                writes_reg = 1'b1;
            end
            `OPCODE_XORI: begin
                alu_op = `ALU_XOR;
                use_imm = 1'b1;
                imm_value = imm_zero;
                writes_reg = 1'b1;
            end
            `OPCODE_LUI: begin
                alu_op = `ALU_PASS_B;
                use_imm = 1'b1;
                imm_value = {instr[15:0], 16'h0000};
                writes_reg = 1'b1;
            end
            // Address is rs plus the sign-extended offset
            `OPCODE_LW: begin
                use_imm = 1'b1;
                mem_read = 1'b1;
                writes_reg = 1'b1;
            end
            `OPCODE_SW: begin
                use_imm = 1'b1;
                mem_write = 1'b1;
            end
            `OPCODE_BEQ: flow = `FLOW_BEQ;
            `OPCODE_BNE: flow = `FLOW_BNE;
            `OPCODE_J:   flow = `FLOW_J;
            default: begin
            end
        endcase
    end

endmodule

//--- source/mips_register_file.sv
`timescale 1ns/1ps

`include "mips_cpu_consts.svh"

module mips_register_file (
    input  logic                    clk,
    input  mips_cpu_pkg::reg_addr_t rs,
    input  mips_cpu_pkg::reg_addr_t rt,
    input  logic                    write_enable,
    input  mips_cpu_pkg::reg_addr_t write_addr,
    input  mips_cpu_pkg::word_t     write_data,
    output mips_cpu_pkg::word_t     rs_value,
    output mips_cpu_pkg::word_t     rt_value,
    output mips_cpu_pkg::word_t     v0
);
    import mips_cpu_pkg::*;

    word_t regs [0:`REG_COUNT-1];

    // Register 0 is hardwired to zero on the read side
    assign rs_value = (rs == '0) ? '0 : regs[rs];
    assign rt_value = (rt == '0) ? '0 : regs[rt];

    assign v0 = regs[`REG_V0];

    always_ff @(posedge clk) begin
        if (write_enable && (write_addr != '0)) begin
            regs[write_addr] <= write_data;
        end
    end

endmodule

//--- source/mips_control.sv
`timescale 1ns/1ps

`include "mips_cpu_consts.svh"

module mips_control (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      waitrequest,
    input  mips_cpu_pkg::word_t       readdata,
    input  mips_cpu_pkg::flow_t       flow,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  logic                      wb_enable,
    input  mips_cpu_pkg::reg_addr_t   wb_addr,
    input  mips_cpu_pkg::word_t       imm_value,
    input  mips_cpu_pkg::word_t       rs_value,
    input  mips_cpu_pkg::word_t       rt_value,
    input  mips_cpu_pkg::word_t       alu_result,
    input  logic                      operands_equal,
    output mips_cpu_pkg::word_t       instr,
    output logic                      rf_write,
    output mips_cpu_pkg::reg_addr_t   rf_write_addr,
    output mips_cpu_pkg::word_t       rf_write_data,
    output mips_cpu_pkg::word_t       address,
    output logic                      read,
    output logic                      write,
    output mips_cpu_pkg::word_t       writedata,
    output logic [3:0]                byteenable,
    output logic                      active
);
    import mips_cpu_pkg::*;

    cpu_state_t state;
    word_t      pc;
    word_t      ir;
    word_t      branch_target;
    logic       delay_pending;

    word_t      pc_plus_4;
    word_t      next_pc;
    word_t      new_target;
    logic       branch_taken;
    logic       is_mem_op;

    assign instr = ir;
    assign pc_plus_4 = pc + 32'd4;
    assign is_mem_op = mem_read || mem_write;

    // A pending target from the previous instruction wins over sequential flow
    assign next_pc = delay_pending ? branch_target : pc_plus_4;

    always_comb begin
        case (flow)
            `FLOW_BEQ: branch_taken = operands_equal;
            `FLOW_BNE: branch_taken = !operands_equal;
            `FLOW_J:   branch_taken = 1'b1;
            `FLOW_JR:  branch_taken = 1'b1;
            default:   branch_taken = 1'b0;
        endcase
    end

    // Branch offsets are relative to the delay slot address
    always_comb begin
        case (flow)
            `FLOW_J:  new_target = {pc_plus_4[31:28], ir[25:0], 2'b00};
            `FLOW_JR: new_target = rs_value;
            default:  new_target = pc_plus_4 + {imm_value[29:0], 2'b00};
        endcase
    end

    // Bus strobes
    assign read = (state == FETCH) || ((state == MEM_ACCESS) && mem_read);
    assign write = (state == MEM_ACCESS) && mem_write;
    assign address = (state == FETCH) ? pc : alu_result;
    assign writedata = rt_value;
    assign byteenable = 4'b1111;
    assign active = (state != HALTED);

    // ALU results retire in EXEC, load data when the read completes
    assign rf_write = ((state == EXEC) && wb_enable && !is_mem_op)
        || ((state == MEM_ACCESS) && mem_read && wb_enable && !waitrequest);
    assign rf_write_addr = wb_addr;
    assign rf_write_data = (state == MEM_ACCESS) ? readdata : alu_result;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= HALTED;
            pc <= `RESET_VECTOR;
            delay_pending <= 1'b0;
        end else begin
            case (state)
                // Leaving reset, pc holds the reset vector so the core starts
                HALTED: begin
                    if (pc != `HALT_ADDRESS) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    if (!waitrequest) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    pc <= next_pc;
                    delay_pending <= branch_taken;
                    if (is_mem_op) begin
                        state <= MEM_ACCESS;
                    end else if (next_pc == `HALT_ADDRESS) begin
                        state <= HALTED;
                    end else begin
                        state <= FETCH;
                    end
                end
                MEM_ACCESS: begin
                    if (!waitrequest) begin
                        state <= (pc == `HALT_ADDRESS) ? HALTED : FETCH;
                    end
                end
                default: begin
                    state <= HALTED;
                end
            endcase
        end
    end

    // Instruction register loads on the completing fetch edge
    always_ff @(posedge clk) begin
        if ((state == FETCH) && !waitrequest) begin
            ir <= readdata;
        end
    end

    always_ff @(posedge clk) begin
        if ((state == EXEC) && branch_taken) begin
            branch_target <= new_target;
        end
    end

endmodule

//--- source/mips_cpu_bus.sv
`timescale 1ns/1ps

module mips_cpu_bus (
    input  logic                clk,
    input  logic                reset,
    output logic                active,
    output mips_cpu_pkg::word_t register_v0,

    // Avalon-MM master
    output mips_cpu_pkg::word_t address,
    output logic                write,
    output logic                read,
    input  logic                waitrequest,
    output mips_cpu_pkg::word_t writedata,
    output logic [3:0]          byteenable,
    input  mips_cpu_pkg::word_t readdata
);
    import mips_cpu_pkg::*;

    word_t     instr;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t wb_addr;
    alu_op_t   alu_op;
    logic      use_imm;
    word_t     imm_value;
    shamt_t    shamt;
    flow_t     flow;
    logic      mem_read;
    logic      mem_write;
    logic      wb_enable;

    word_t     rs_value;
    word_t     rt_value;
    word_t     alu_result;
    logic      operands_equal;

    logic      rf_write;
    reg_addr_t rf_write_addr;
    word_t     rf_write_data;

    mips_control control_i (
        .clk            (clk),
        .reset          (reset),
        .waitrequest    (waitrequest),
        .readdata       (readdata),
        .flow           (flow),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .wb_enable      (wb_enable),
        .wb_addr        (wb_addr),
        .imm_value      (imm_value),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .alu_result     (alu_result),
        .operands_equal (operands_equal),
        .instr          (instr),
        .rf_write       (rf_write),
        .rf_write_addr  (rf_write_addr),
        .rf_write_data  (rf_write_data),
        .address        (address),
        .read           (read),
        .write          (write),
        .writedata      (writedata),
        .byteenable     (byteenable),
        .active         (active)
    );

    mips_decoder decoder_i (
        .instr     (instr),
        .rs        (rs),
        .rt        (rt),
        .wb_addr   (wb_addr),
        .alu_op    (alu_op),
        .use_imm   (use_imm),
        .imm_value (imm_value),
        .shamt     (shamt),
        .flow      (flow),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .wb_enable (wb_enable)
    );

    mips_alu alu_i (
        .alu_op         (alu_op),
        .rs_value       (rs_value),
        .rt_value       (rt_value),
        .imm_value      (imm_value),
        .use_imm        (use_imm),
        .shamt          (shamt),
        .result         (alu_result),
        .operands_equal (operands_equal)
    );

    mips_register_file register_file_i (
        .clk          (clk),
        .rs           (rs),
        .rt           (rt),
        .write_enable (rf_write),
        .write_addr   (rf_write_addr),
        .write_data   (rf_write_data),
        .rs_value     (rs_value),
        .rt_value     (rt_value),
        .v0           (register_v0)
    );

endmodule

//--- bench/mips_tb_clock.sv
`timescale 1ns/1ps

module mips_tb_clock (
    output logic clk
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

endmodule

//--- bench/mips_avalon_memory.sv
`timescale 1ns/1ps

module mips_avalon_memory (
    input  logic                clk,
    input  logic                stall_enable,
    input  mips_cpu_pkg::word_t address,
    input  logic                write,
    input  mips_cpu_pkg::word_t writedata,
    output logic                waitrequest,
    output mips_cpu_pkg::word_t readdata
);
    import mips_cpu_pkg::*;

    // Programs start at index 0, data lives from byte offset 0x200
    word_t       words [0:255];
    logic [31:0] lfsr_state;

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            words[i] = '0;
        end
        lfsr_state = 32'h9b9a_87fc;
        waitrequest = 1'b0;
    end

    assign readdata = words[address[9:2]];

    always @(posedge clk) begin
        if (write && !waitrequest) begin
            words[address[9:2]] = writedata;
        end
        // One new bit per cycle decides the stall seen at the next edge
        lfsr_state = lfsr_step(lfsr_state);
        #2 waitrequest = stall_enable && lfsr_state[0];
    end

endmodule

//--- bench/mips_cpu_assertions.sv
`timescale 1ns/1ps

module mips_cpu_assertions (
    input logic                clk,
    input logic                reset,
    input logic                active,
    input mips_cpu_pkg::word_t address,
    input logic                read,
    input logic                write,
    input mips_cpu_pkg::word_t writedata,
    input logic                waitrequest
);

    int failure_count = 0;

    read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else begin
            failure_count++;
            $error("read and write are high in the same cycle");
        end

    // A stalled access keeps its request unchanged
    request_held: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read)
            && $stable(write) && (!write || $stable(writedata)))
        else begin
            failure_count++;
            $error("bus request changed while waitrequest was high");
        end

    idle_when_inactive: assert property (@(posedge clk)
        !active && !reset |-> !read && !write)
        else begin
            failure_count++;
            $error("bus strobe raised while the core is not active");
        end

endmodule

bind mips_cpu_bus mips_cpu_assertions assertions_i (.*);

//--- bench/mips_cpu_tb.sv
`timescale 1ns/1ps

`include "mips_cpu_consts.svh"

module mips_cpu_tb;
    import mips_cpu_pkg::*;

    typedef struct packed {
        logic [11:0] op;
        word_t       a;
        word_t       b;
        logic [15:0] imm;
    } row_t;

    localparam int ROW_COUNT = 28;
    localparam int CYCLES_PER_RUN = 200;

    // Operation is {opcode, function}
    // SW rows also read back with LW
    localparam row_t ROWS [ROW_COUNT] = '{
        '{{`OPCODE_SPECIAL, `FUNCTION_ADDU}, 32'h1234_5678, 32'h8765_4321, 16'h0000},
        '{{`OPCODE_SPECIAL, `FUNCTION_ADDU}, 32'hffff_ffff, 32'h0000_0002, 16'h0000},
        '{{`OPCODE_SPECIAL, `FUNCTION_SUBU}, 32'h0000_0005, 32'h0000_0009, 16'h0000},
        '{{`OPCODE_SPECIAL, `FUNCTION_AND},  32'hf0f0_a5a5, 32'hff00_ff00, 16'h0000},
        '{{`OPCODE_SPECIAL, `FUNCTION_OR},   32'hf0f0_a5a5, 32'h0f0f_0000, 16'h0000},
        '{{`OPCODE_SPECIAL, `FUNCTION_XOR},  32'haaaa_5555, 32'hffff_0000, 16'h0000},
        '{{`OPCODE_SPECIAL, `FUNCTION_SLT},  32'h8000_0000, 32'h7fff_ffff, 16'h0000},
        '{{`OPCODE_SPECIAL, `FUNCTION_SLT},  32'h7fff_ffff, 32'h8000_0000, 16'h0000},
        '{{`OPCODE_SPECIAL, `FUNCTION_SLTU}, 32'h8000_0000, 32'h7fff_ffff, 16'h0000},
        '{{`OPCODE_SPECIAL, `FUNCTION_SLTU}, 32'h0000_0001, 32'hffff_ffff, 16'h0000},
        '{{`OPCODE_SPECIAL, `FUNCTION_SLL},  32'h0000_0000, 32'h8000_0001, 16'h0004},
        '{{`OPCODE_SPECIAL, `FUNCTION_SRL},  32'h0000_0000, 32'h8000_00f0, 16'h0004},
        '{{`OPCODE_SPECIAL, `FUNCTION_SRA},  32'h0000_0000, 32'h8000_00f0, 16'h0004},
        '{{`OPCODE_SPECIAL, `FUNCTION_SRA},  32'h0000_0000, 32'h7000_0000, 16'h001f},
        '{{`OPCODE_ADDIU, 6'h00}, 32'h0000_1000, 32'h0000_0000, 16'hffff},
        '{{`OPCODE_ANDI,  6'h00}, 32'hffff_ffff, 32'h0000_0000, 16'h8001},
        '{{`OPCODE_ORI,   6'h00}, 32'h1234_0000, 32'h0000_0000, 16'h8765},
        '{{`OPCODE_XORI,  6'h00}, 32'hffff_0000, 32'h0000_0000, 16'hffff},
        '{{`OPCODE_SLTI,  6'h00}, 32'hffff_fffe, 32'h0000_0000, 16'hffff},
        '{{`OPCODE_SLTIU, 6'h00}, 32'h0000_0005, 32'h0000_0000, 16'hffff},
        '{{`OPCODE_LUI,   6'h00}, 32'h0000_0000, 32'h0000_0000, 16'habcd},
        '{{`OPCODE_SW,    6'h00}, 32'h0000_0240, 32'hcafe_f00d, 16'h0010},
        '{{`OPCODE_SW,    6'h00}, 32'h0000_0300, 32'h1357_9bdf, 16'hfff0},
        '{{`OPCODE_BEQ,   6'h00}, 32'h0000_0005, 32'h0000_0005, 16'h0000},
        '{{`OPCODE_BEQ,   6'h00}, 32'h0000_0005, 32'h0000_0006, 16'h0000},
        '{{`OPCODE_BNE,   6'h00}, 32'h0000_0005, 32'h0000_0006, 16'h0000},
        '{{`OPCODE_BNE,   6'h00}, 32'h0000_0007, 32'h0000_0007, 16'h0000},
        '{{`OPCODE_J,     6'h00}, 32'h0000_0000, 32'h0000_0000, 16'h0000}
    };

    logic       clk;
    logic       reset;
    logic       stall_enable;
    logic       waitrequest;
    word_t      readdata;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       read;
    logic       write;
    word_t      writedata;
    logic [3:0] byteenable;

    int check_count = 0;
    int value_errors = 0;
    int other_errors = 0;
    int next_slot;

    // What the bus showed during the current run
    logic       first_seen;
    word_t      first_address;
    logic       first_read;
    logic       first_write;
    logic [3:0] first_byteenable;
    word_t      write_count;
    word_t      last_write_address;
    word_t      last_write_data;
    int         late_accesses;

    mips_tb_clock clock_i (
        .clk (clk)
    );

    mips_avalon_memory memory_i (
        .clk          (clk),
        .stall_enable (stall_enable),
        .address      (address),
        .write        (write),
        .writedata    (writedata),
        .waitrequest  (waitrequest),
        .readdata     (readdata)
    );

    mips_cpu_bus mips_cpu_bus_i (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    always @(posedge clk) begin
        if (reset) begin
            first_seen <= 1'b0;
            write_count <= '0;
            late_accesses <= 0;
        end else begin
            if (active && !first_seen) begin
                first_seen <= 1'b1;
                first_address <= address;
                first_read <= read;
                first_write <= write;
                first_byteenable <= byteenable;
            end
            if (write && !waitrequest) begin
                write_count <= write_count + 32'd1;
                last_write_address <= address;
                last_write_data <= writedata;
            end
            if (!active && (read || write)) begin
                late_accesses <= late_accesses + 1;
            end
        end
    end

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        check_count++;
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        check_count++;
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    function automatic word_t i_type(input opcode_t op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input shamt_t sh, input funct_t fn);
        return {`OPCODE_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    // Expected v0 after the program built for a row
    function automatic word_t reference_result(input row_t row);
        word_t sext;
        word_t zext;
        sext = {{16{row.imm[15]}}, row.imm};
        zext = {16'h0000, row.imm};
        case (row.op[11:6])
            `OPCODE_SPECIAL: begin
                case (row.op[5:0])
                    `FUNCTION_ADDU: return row.a + row.b;
                    `FUNCTION_SUBU: return row.a - row.b;
                    `FUNCTION_AND:  return row.a & row.b;
                    `FUNCTION_OR:   return row.a | row.b;
                    `FUNCTION_XOR:  return row.a ^ row.b;
                    `FUNCTION_SLT:  return ($signed(row.a) < $signed(row.b)) ? 32'd1 : 32'd0;
                    `FUNCTION_SLTU: return (row.a < row.b) ? 32'd1 : 32'd0;
                    `FUNCTION_SLL:  return row.b << row.imm[4:0];
                    `FUNCTION_SRL:  return row.b >> row.imm[4:0];
                    `FUNCTION_SRA:  return $signed(row.b) >>> row.imm[4:0];
                    default:        return '0;
                endcase
            end
            `OPCODE_ADDIU: return row.a + sext;
            `OPCODE_ANDI:  return row.a & zext;
            `OPCODE_ORI:   return row.a | zext;
            `OPCODE_XORI:  return row.a ^ zext;
            `OPCODE_SLTI:  return ($signed(row.a) < $signed(sext)) ? 32'd1 : 32'd0;
            `OPCODE_SLTIU: return (row.a < sext) ? 32'd1 : 32'd0;
            `OPCODE_LUI:   return {row.imm, 16'h0000};
            `OPCODE_SW:    return row.b;
            // 1 before the branch, +2 delay slot, +4 only when not taken, +8 at target
            `OPCODE_BEQ:   return (row.a == row.b) ? 32'd11 : 32'd15;
            `OPCODE_BNE:   return (row.a != row.b) ? 32'd11 : 32'd15;
            `OPCODE_J:     return 32'd11;
            default:       return '0;
        endcase
    endfunction

    task automatic place(input word_t instr);
        memory_i.words[next_slot] = instr;
        next_slot++;
    endtask

    // Operands go to $8 and $9, the result to v0
    task automatic build_program(input row_t row);
        opcode_t op;
        word_t   target;
        op = row.op[11:6];
        // Unused words differ per index and decode as no-ops
        for (int i = 0; i < 256; i++) begin
            memory_i.words[i] = 32'hdead_0000 + i;
        end
        next_slot = 0;
        place(i_type(`OPCODE_LUI, 5'd0, 5'd8, row.a[31:16]));
        place(i_type(`OPCODE_ORI, 5'd8, 5'd8, row.a[15:0]));
        place(i_type(`OPCODE_LUI, 5'd0, 5'd9, row.b[31:16]));
        place(i_type(`OPCODE_ORI, 5'd9, 5'd9, row.b[15:0]));
        case (op)
            `OPCODE_SPECIAL: place(r_type(5'd8, 5'd9, 5'd2, row.imm[4:0], row.op[5:0]));
            `OPCODE_SW: begin
                place(i_type(`OPCODE_SW, 5'd8, 5'd9, row.imm));
                place(i_type(`OPCODE_LW, 5'd8, 5'd2, row.imm));
            end
            `OPCODE_BEQ, `OPCODE_BNE, `OPCODE_J: begin
                place(i_type(`OPCODE_ADDIU, 5'd0, 5'd2, 16'd1));
                // Target is three words past the branch
                target = `RESET_VECTOR + 4 * (next_slot + 3);
                if (op == `OPCODE_J) begin
                    place({`OPCODE_J, target[27:2]});
                end else begin
                    place(i_type(op, 5'd8, 5'd9, 16'd2));
                end
                place(i_type(`OPCODE_ADDIU, 5'd2, 5'd2, 16'd2));
                place(i_type(`OPCODE_ADDIU, 5'd2, 5'd2, 16'd4));
                place(i_type(`OPCODE_ADDIU, 5'd2, 5'd2, 16'd8));
            end
            default: place(i_type(op, 5'd8, 5'd2, row.imm));
        endcase
        place(r_type(5'd0, 5'd0, 5'd0, 5'd0, `FUNCTION_JR));
        place(32'h0000_0000);
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #2;
    endtask

    task automatic run_row(input row_t row, input logic stalls);
        word_t store_address;
        next_cycle();
        reset = 1'b1;
        stall_enable = stalls;
        build_program(row);
        repeat (5) begin
            next_cycle();
        end
        check_flag("active", active, 1'b0);
        reset = 1'b0;
        // The core leaves reset on the first edge after release
        next_cycle();
        check_flag("active", active, 1'b1);
        while (active) begin
            next_cycle();
        end
        // A few idle cycles to catch bus activity after the halt
        repeat (5) begin
            next_cycle();
        end
        check_word("register_v0", register_v0, reference_result(row));
        check_word("address", first_address, `RESET_VECTOR);
        check_flag("read", first_read, 1'b1);
        check_flag("write", first_write, 1'b0);
        check_word("byteenable", {28'h0, first_byteenable}, 32'h0000_000f);
        if (row.op[11:6] == `OPCODE_SW) begin
            store_address = row.a + {{16{row.imm[15]}}, row.imm};
            check_word("write count", write_count, 32'd1);
            check_word("address", last_write_address, store_address);
            check_word("writedata", last_write_data, row.b);
        end else begin
            check_word("write count", write_count, 32'd0);
        end
        if (late_accesses != 0) begin
            other_errors++;
            $display("Bus access seen after the core halted, operation %h", row.op);
        end
    endtask

    initial begin
        reset = 1'b1;
        stall_enable = 1'b0;
        // Second pass repeats every row with random stalls
        for (int pass = 0; pass < 2; pass++) begin
            for (int i = 0; i < ROW_COUNT; i++) begin
                run_row(ROWS[i], pass == 1);
            end
        end
        $display("Checks: %0d, value errors: %0d, other errors: %0d, assertion failures: %0d",
                 check_count, value_errors, other_errors,
                 mips_cpu_bus_i.assertions_i.failure_count);
        if (value_errors == 0 && other_errors == 0
                && mips_cpu_bus_i.assertions_i.failure_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // Two runs of every row with a fixed cycle budget for each
    initial begin
        #(ROW_COUNT * 2 * CYCLES_PER_RUN * 20);
        $display("Timeout: the core did not halt within the expected time");
        $display("Verification failed");
        $finish;
    end

endmodule

//--- mips_cpu.f
+incdir+include
source/mips_cpu_pkg.sv
source/mips_alu.sv
source/mips_decoder.sv
source/mips_register_file.sv
source/mips_control.sv
source/mips_cpu_bus.sv
bench/mips_tb_clock.sv
bench/mips_avalon_memory.sv
bench/mips_cpu_assertions.sv
bench/mips_cpu_tb.sv
